// File: hw/tl_axi_pkg.sv
// ******************************
// PCIe TL to AXI bridge types
// ******************************
package tl_axi_pkg;

    // ******************************
    // Widths and constants
    // ******************************
    localparam int ADDR_W        = 64;                   // AXI address
    localparam int DATA_W        = 256;                  // One data beat
    localparam int BEAT_BYTES    = DATA_W / 8;           // 32B per beat
    localparam int RCB_BYTES     = 128;                  // Read completion boundary
    localparam int BEATS_PER_RCB = RCB_BYTES / BEAT_BYTES;

    // ******************************
    // Opcodes and states
    // ******************************
    typedef enum logic [7:0] {
        MEM_RD = 8'h20,                                  // 4DW header, no data
        MEM_WR = 8'h60,                                  // 4DW header, with data
        CPL_D  = 8'h4A                                   // Completion with data
    } tlp_fmt_type_e;

    typedef enum logic [2:0] {
        CPL_SC = 3'b000,                                 // Successful completion
        CPL_UR = 3'b001                                  // Unsupported request
    } cpl_status_e;

    typedef enum logic {
        HEADER,
        PAYLOAD
    } pw_state_e;

    typedef enum logic {
        NP_READ,
        CPL_GEN
    } np_state_e;

    // ******************************
    // Header and channel payloads
    // ******************************
    // Request header, already decoded from the TLP
    typedef struct packed {
        logic [9:0]        length_dw;
        logic [ADDR_W-1:0] addr;
        logic [9:0]        tag;
        logic [15:0]       requester_id;
    } tlp_req_hdr_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;                          // Beats minus one
    } axi_a_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        tlp_fmt_type_e fmt_type;
        cpl_status_e   status;
        logic [9:0]    length_dw;
        logic [15:0]   completer_id;
        logic [11:0]   byte_count;                       // Remaining incl. this piece
        logic [15:0]   requester_id;
        logic [9:0]    tag;
        logic [6:0]    lower_addr;
    } tlp_cpl_hdr_t;

endpackage

// File: hw/tl_fifo.sv
// ******************************
// Synchronous FWFT FIFO
// ******************************
`timescale 1ns/1ns
module tl_fifo #(
    parameter int  DEPTH_LG2 = 4,
    parameter type entry_t   = logic
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   wren_i,
    input  entry_t wdata_i,
    output logic   full_o,
    input  logic   rden_i,
    output entry_t rdata_o,
    output logic   empty_o
);
    localparam int DEPTH = 1 << DEPTH_LG2;

    entry_t             mem [DEPTH];
    logic [DEPTH_LG2:0] wr_ptr;                          // MSB is the wrap bit
    logic [DEPTH_LG2:0] rd_ptr;
    logic [DEPTH_LG2:0] wr_ptr_nxt;
    logic [DEPTH_LG2:0] rd_ptr_nxt;
    logic               full_q;
    logic               empty_q;

    assign wr_ptr_nxt = wr_ptr + {{DEPTH_LG2{1'b0}}, wren_i};
    assign rd_ptr_nxt = rd_ptr + {{DEPTH_LG2{1'b0}}, rden_i};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            full_q  <= 1'b0;
            empty_q <= 1'b1;
        end else begin
            wr_ptr  <= wr_ptr_nxt;
            rd_ptr  <= rd_ptr_nxt;
            empty_q <= (wr_ptr_nxt == rd_ptr_nxt);
            full_q  <= (wr_ptr_nxt[DEPTH_LG2] != rd_ptr_nxt[DEPTH_LG2]) &&
                       (wr_ptr_nxt[DEPTH_LG2-1:0] == rd_ptr_nxt[DEPTH_LG2-1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (wren_i) begin
            mem[wr_ptr[DEPTH_LG2-1:0]] <= wdata_i;
        end
    end

    assign rdata_o = mem[rd_ptr[DEPTH_LG2-1:0]];         // Head entry, no output flop
    assign full_o  = full_q;
    assign empty_o = empty_q;

endmodule

// File: hw/tl_posted_wr.sv
// ******************************
// Posted write to AXI write
// ******************************
`timescale 1ns/1ns
module tl_posted_wr (
    input  logic                          clk,
    input  logic                          rst_n,
    input  tl_axi_pkg::tlp_req_hdr_t      hdr_i,
    input  logic                          hdr_empty_i,
    output logic                          hdr_rden_o,
    input  logic [tl_axi_pkg::DATA_W-1:0] data_i,
    input  logic                          data_empty_i,
    output logic                          data_rden_o,
    output tl_axi_pkg::axi_a_t            aw_o,
    output logic                          aw_valid_o,
    input  logic                          aw_ready_i,
    output tl_axi_pkg::axi_w_t            w_o,
    output logic                          w_valid_o,
    input  logic                          w_ready_i
);
    localparam int DW_PER_BEAT = tl_axi_pkg::BEAT_BYTES / 4;

    tl_axi_pkg::pw_state_e state;
    logic [7:0]            beat_cnt;                     // Beats left after the current one

    // ******************************
    // AW and W channel drive
    // ******************************
    assign aw_o.addr = hdr_i.addr;
    assign aw_o.len  = 8'(hdr_i.length_dw / DW_PER_BEAT) - 8'd1;

    assign aw_valid_o = (state == tl_axi_pkg::HEADER) && !hdr_empty_i;
    assign hdr_rden_o = aw_valid_o && aw_ready_i;        // Pop on AW handshake

    assign w_o.data    = data_i;
    assign w_o.last    = (state == tl_axi_pkg::PAYLOAD) && (beat_cnt == 8'd0);
    assign w_valid_o   = (state == tl_axi_pkg::PAYLOAD) && !data_empty_i;
    assign data_rden_o = w_valid_o && w_ready_i;         // One beat per W handshake

    // ******************************
    // Burst control
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= tl_axi_pkg::HEADER;
            beat_cnt <= 8'd0;
        end else begin
            case (state)
                tl_axi_pkg::HEADER: begin
                    if (hdr_rden_o) begin
                        state    <= tl_axi_pkg::PAYLOAD;
                        beat_cnt <= aw_o.len;
                    end
                end
                tl_axi_pkg::PAYLOAD: begin
                    if (data_rden_o) begin
                        beat_cnt <= beat_cnt - 8'd1;
                        if (w_o.last) begin
                            state <= tl_axi_pkg::HEADER;  // Burst done
                        end
                    end
                end
                default: begin
                    state <= tl_axi_pkg::HEADER;
                end
            endcase
        end
    end

endmodule

// File: hw/tl_np_rd_split.sv
// ******************************
// Read split at the RCB
// ******************************
`timescale 1ns/1ns
module tl_np_rd_split (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [15:0]                   config_bdf_i,
    input  tl_axi_pkg::tlp_req_hdr_t      hdr_i,
    input  logic                          hdr_empty_i,
    output logic                          hdr_rden_o,
    output tl_axi_pkg::axi_a_t            ar_wdata_o,
    input  logic                          ar_full_i,
    output logic                          ar_wren_o,
    output tl_axi_pkg::tlp_cpl_hdr_t      cpl_hdr_o,
    input  logic                          cpl_full_i,
    output logic                          cpl_wren_o
);
    tl_axi_pkg::np_state_e         state;
    logic [tl_axi_pkg::ADDR_W-1:0] addr_q;               // Start of current piece
    logic [11:0]                   remain_q;             // Bytes left incl. current piece
    logic [9:0]                    tag_q;
    logic [15:0]                   req_id_q;
    logic [7:0]                    len_q;                // Current piece beats minus one
    logic [11:0]                   piece_bytes;
    logic                          push;

    // Beats minus one from addr up to the next boundary or the end of the request
    function automatic logic [7:0] piece_len(input logic [tl_axi_pkg::ADDR_W-1:0] a,
                                             input logic [11:0] bytes);
        logic [7:0] to_rcb;
        logic [7:0] left;
        to_rcb = 8'(tl_axi_pkg::BEATS_PER_RCB) -
                 8'((a % tl_axi_pkg::RCB_BYTES) / tl_axi_pkg::BEAT_BYTES);
        left   = 8'(bytes / tl_axi_pkg::BEAT_BYTES);
        piece_len = ((left < to_rcb) ? left : to_rcb) - 8'd1;
    endfunction

    assign piece_bytes = 12'((len_q + 8'd1) * tl_axi_pkg::BEAT_BYTES);

    assign hdr_rden_o = (state == tl_axi_pkg::NP_READ) && !hdr_empty_i;
    assign push       = (state == tl_axi_pkg::CPL_GEN) && !ar_full_i && !cpl_full_i;
    assign ar_wren_o  = push;
    assign cpl_wren_o = push;

    // ******************************
    // AR entry and completion header
    // ******************************
    assign ar_wdata_o.addr = addr_q;
    assign ar_wdata_o.len  = len_q;

    always_comb begin
        cpl_hdr_o.fmt_type     = tl_axi_pkg::CPL_D;
        cpl_hdr_o.status       = tl_axi_pkg::CPL_SC;
        cpl_hdr_o.length_dw    = 10'(piece_bytes / 4);
        cpl_hdr_o.completer_id = config_bdf_i;
        cpl_hdr_o.byte_count   = remain_q;
        cpl_hdr_o.requester_id = req_id_q;
        cpl_hdr_o.tag          = tag_q;
        cpl_hdr_o.lower_addr   = 7'(addr_q % tl_axi_pkg::RCB_BYTES);
    end

    // ******************************
    // Split state machine
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= tl_axi_pkg::NP_READ;
        end else begin
            case (state)
                tl_axi_pkg::NP_READ: begin
                    if (hdr_rden_o) begin
                        state <= tl_axi_pkg::CPL_GEN;
                    end
                end
                tl_axi_pkg::CPL_GEN: begin
                    if (push && (remain_q == piece_bytes)) begin
                        state <= tl_axi_pkg::NP_READ;  // Last piece queued
                    end
                end
                default: begin
                    state <= tl_axi_pkg::NP_READ;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_rden_o) begin
            addr_q   <= hdr_i.addr;
            remain_q <= {hdr_i.length_dw, 2'b00};
            tag_q    <= hdr_i.tag;
            req_id_q <= hdr_i.requester_id;
            len_q    <= piece_len(hdr_i.addr, {hdr_i.length_dw, 2'b00});
        end else if (push) begin
            addr_q   <= addr_q + tl_axi_pkg::ADDR_W'(piece_bytes);
            remain_q <= remain_q - piece_bytes;
            len_q    <= piece_len(addr_q + tl_axi_pkg::ADDR_W'(piece_bytes),
                                  remain_q - piece_bytes);
        end
    end

endmodule

// File: hw/tl_axi_master.sv
// ******************************
// PCIe TL to AXI master bridge
// ******************************
`timescale 1ns/1ns
module tl_axi_master #(
    parameter int RX_DEPTH_LG2 = 4,
    parameter int TX_DEPTH_LG2 = 3
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [15:0]                   config_bdf_i,
    // Posted requests
    input  tl_axi_pkg::tlp_req_hdr_t      p_hdr_i,
    input  logic                          p_hdr_wren_i,
    output logic                          p_hdr_full_o,
    input  logic [tl_axi_pkg::DATA_W-1:0] p_data_i,
    input  logic                          p_data_wren_i,
    output logic                          p_data_full_o,
    // Non-posted requests
    input  tl_axi_pkg::tlp_req_hdr_t      np_hdr_i,
    input  logic                          np_hdr_wren_i,
    output logic                          np_hdr_full_o,
    // AXI write
    output tl_axi_pkg::axi_a_t            aw_o,
    output logic                          aw_valid_o,
    input  logic                          aw_ready_i,
    output tl_axi_pkg::axi_w_t            w_o,
    output logic                          w_valid_o,
    input  logic                          w_ready_i,
    // AXI read
    output tl_axi_pkg::axi_a_t            ar_o,
    output logic                          ar_valid_o,
    input  logic                          ar_ready_i,
    input  tl_axi_pkg::axi_r_t            r_i,
    input  logic                          r_valid_i,
    output logic                          r_ready_o,
    // Completions
    output tl_axi_pkg::tlp_cpl_hdr_t      cpl_hdr_o,
    output logic                          cpl_hdr_empty_o,
    input  logic                          cpl_hdr_rden_i,
    output logic [tl_axi_pkg::DATA_W-1:0] cpl_data_o,
    output logic                          cpl_data_empty_o,
    input  logic                          cpl_data_rden_i
);
    tl_axi_pkg::tlp_req_hdr_t      p_hdr;
    logic                          p_hdr_empty;
    logic                          p_hdr_rden;
    logic [tl_axi_pkg::DATA_W-1:0] p_data;
    logic                          p_data_empty;
    logic                          p_data_rden;
    tl_axi_pkg::tlp_req_hdr_t      np_hdr;
    logic                          np_hdr_empty;
    logic                          np_hdr_rden;
    tl_axi_pkg::axi_a_t            ar_wdata;
    logic                          ar_full;
    logic                          ar_wren;
    logic                          ar_empty;
    logic                          ar_rden;
    tl_axi_pkg::tlp_cpl_hdr_t      cpl_hdr;
    logic                          cpl_hdr_full;
    logic                          cpl_hdr_wren;
    logic                          cpl_data_full;
    logic                          cpl_data_wren;

    // ******************************
    // Receive FIFOs
    // ******************************
    tl_fifo #(.DEPTH_LG2(RX_DEPTH_LG2), .entry_t(tl_axi_pkg::tlp_req_hdr_t)) u_p_hdr_fifo (
        .clk(clk), .rst_n(rst_n),
        .wren_i(p_hdr_wren_i), .wdata_i(p_hdr_i), .full_o(p_hdr_full_o),
        .rden_i(p_hdr_rden), .rdata_o(p_hdr), .empty_o(p_hdr_empty)
    );

    tl_fifo #(
        .DEPTH_LG2(RX_DEPTH_LG2), .entry_t(logic [tl_axi_pkg::DATA_W-1:0])
    ) u_p_data_fifo (
        .clk(clk), .rst_n(rst_n),
        .wren_i(p_data_wren_i), .wdata_i(p_data_i), .full_o(p_data_full_o),
        .rden_i(p_data_rden), .rdata_o(p_data), .empty_o(p_data_empty)
    );

    tl_fifo #(.DEPTH_LG2(RX_DEPTH_LG2), .entry_t(tl_axi_pkg::tlp_req_hdr_t)) u_np_hdr_fifo (
        .clk(clk), .rst_n(rst_n),
        .wren_i(np_hdr_wren_i), .wdata_i(np_hdr_i), .full_o(np_hdr_full_o),
        .rden_i(np_hdr_rden), .rdata_o(np_hdr), .empty_o(np_hdr_empty)
    );

    // ******************************
    // Request engines
    // ******************************
    tl_posted_wr u_posted_wr (
        .clk(clk), .rst_n(rst_n),
        .hdr_i(p_hdr), .hdr_empty_i(p_hdr_empty), .hdr_rden_o(p_hdr_rden),
        .data_i(p_data), .data_empty_i(p_data_empty), .data_rden_o(p_data_rden),
        .aw_o(aw_o), .aw_valid_o(aw_valid_o), .aw_ready_i(aw_ready_i),
        .w_o(w_o), .w_valid_o(w_valid_o), .w_ready_i(w_ready_i)
    );

    tl_np_rd_split u_np_rd_split (
        .clk(clk), .rst_n(rst_n), .config_bdf_i(config_bdf_i),
        .hdr_i(np_hdr), .hdr_empty_i(np_hdr_empty), .hdr_rden_o(np_hdr_rden),
        .ar_wdata_o(ar_wdata), .ar_full_i(ar_full), .ar_wren_o(ar_wren),
        .cpl_hdr_o(cpl_hdr), .cpl_full_i(cpl_hdr_full), .cpl_wren_o(cpl_hdr_wren)
    );

    // ******************************
    // AR queue and transmit FIFOs
    // ******************************
    tl_fifo #(.DEPTH_LG2(RX_DEPTH_LG2), .entry_t(tl_axi_pkg::axi_a_t)) u_ar_fifo (
        .clk(clk), .rst_n(rst_n),
        .wren_i(ar_wren), .wdata_i(ar_wdata), .full_o(ar_full),
        .rden_i(ar_rden), .rdata_o(ar_o), .empty_o(ar_empty)
    );

    assign ar_valid_o = !ar_empty;
    assign ar_rden    = ar_valid_o && ar_ready_i;        // Pop on AR handshake

    tl_fifo #(.DEPTH_LG2(TX_DEPTH_LG2), .entry_t(tl_axi_pkg::tlp_cpl_hdr_t)) u_cpl_hdr_fifo (
        .clk(clk), .rst_n(rst_n),
        .wren_i(cpl_hdr_wren), .wdata_i(cpl_hdr), .full_o(cpl_hdr_full),
        .rden_i(cpl_hdr_rden_i), .rdata_o(cpl_hdr_o), .empty_o(cpl_hdr_empty_o)
    );

    assign r_ready_o     = !cpl_data_full;
    assign cpl_data_wren = r_valid_i && r_ready_o;       // Capture each R beat

    tl_fifo #(
        .DEPTH_LG2(TX_DEPTH_LG2), .entry_t(logic [tl_axi_pkg::DATA_W-1:0])
    ) u_cpl_data_fifo (
        .clk(clk), .rst_n(rst_n),
        .wren_i(cpl_data_wren), .wdata_i(r_i.data), .full_o(cpl_data_full),
        .rden_i(cpl_data_rden_i), .rdata_o(cpl_data_o), .empty_o(cpl_data_empty_o)
    );

endmodule

// File: verif/tb_tl_axi_master.sv
// ******************************
// TL to AXI bridge testbench
// ******************************
`timescale 1ns/1ns
module tb_tl_axi_master;

    typedef struct packed {
        tl_axi_pkg::tlp_fmt_type_e kind;
        logic [31:0]               addr;
        logic [9:0]                len_dw;
        logic [9:0]                tag;
    } stim_row_t;

    localparam int          NUM_ROWS    = 7;
    localparam int          CYCLE_LIMIT = 200 * NUM_ROWS + 100;
    localparam logic [15:0] CFG_BDF     = 16'h0A18;

    // Kind, address, length in DW, tag
    stim_row_t stim [NUM_ROWS] = '{
        '{tl_axi_pkg::MEM_WR, 32'h0000_1000, 10'd16,  10'd1},
        '{tl_axi_pkg::MEM_RD, 32'h0000_2000, 10'd32,  10'd2},  // Exactly one RCB
        '{tl_axi_pkg::MEM_RD, 32'h0000_3060, 10'd64,  10'd3},  // 256B at offset 0x60
        '{tl_axi_pkg::MEM_WR, 32'h0000_4020, 10'd64,  10'd4},
        '{tl_axi_pkg::MEM_RD, 32'h0000_5040, 10'd128, 10'd5},  // 512B, five pieces
        '{tl_axi_pkg::MEM_RD, 32'h0000_6000, 10'd8,   10'd6},
        '{tl_axi_pkg::MEM_WR, 32'h0000_7000, 10'd8,   10'd7}
    };

    logic                          clk;
    logic                          rst_n;
    logic [15:0]                   config_bdf_i;
    tl_axi_pkg::tlp_req_hdr_t      p_hdr_i;
    logic                          p_hdr_wren_i;
    logic                          p_hdr_full_o;
    logic [tl_axi_pkg::DATA_W-1:0] p_data_i;
    logic                          p_data_wren_i;
    logic                          p_data_full_o;
    tl_axi_pkg::tlp_req_hdr_t      np_hdr_i;
    logic                          np_hdr_wren_i;
    logic                          np_hdr_full_o;
    tl_axi_pkg::axi_a_t            aw_o;
    logic                          aw_valid_o;
    logic                          aw_ready_i;
    tl_axi_pkg::axi_w_t            w_o;
    logic                          w_valid_o;
    logic                          w_ready_i;
    tl_axi_pkg::axi_a_t            ar_o;
    logic                          ar_valid_o;
    logic                          ar_ready_i;
    tl_axi_pkg::axi_r_t            r_i;
    logic                          r_valid_i;
    logic                          r_ready_o;
    tl_axi_pkg::tlp_cpl_hdr_t      cpl_hdr_o;
    logic                          cpl_hdr_empty_o;
    logic                          cpl_hdr_rden_i;
    logic [tl_axi_pkg::DATA_W-1:0] cpl_data_o;
    logic                          cpl_data_empty_o;
    logic                          cpl_data_rden_i;

    tl_axi_pkg::axi_a_t            exp_aw [$];
    tl_axi_pkg::axi_w_t            exp_w [$];
    tl_axi_pkg::axi_a_t            exp_ar [$];
    tl_axi_pkg::tlp_cpl_hdr_t      exp_cpl [$];
    logic [tl_axi_pkg::DATA_W-1:0] exp_rdata [$];
    tl_axi_pkg::axi_r_t            r_pending [$];                // Beats owed on R
    int                            cycle_cnt      = 0;

    tl_axi_master #(.RX_DEPTH_LG2(4), .TX_DEPTH_LG2(3)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ******************************
    // Helpers
    // ******************************
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_val(input string what, input logic [255:0] act,
                             input logic [255:0] exp);
        if (act !== exp) begin
            $display("error at %0t ns: %s mismatch, got %0h expected %0h",
                     $time, what, act, exp);
            $display("TEST FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    function automatic logic [255:0] beat_word(input logic [63:0] a);
        return {4{a}};                                       // Slave data is the beat address
    endfunction

    function automatic logic [255:0] random_beat();
        logic [255:0] d;
        for (int j = 0; j < 8; j++) begin
            d[j*32 +: 32] = $urandom;
        end
        return d;
    endfunction

    function automatic bit all_done();
        return exp_aw.size() == 0 && exp_w.size() == 0 && exp_ar.size() == 0 &&
               exp_cpl.size() == 0 && exp_rdata.size() == 0 && r_pending.size() == 0;
    endfunction

    // Cut a read at each 128B boundary and queue what the bridge should emit
    task automatic expect_read(input stim_row_t row, input logic [15:0] req_id);
        logic [63:0]              a;
        logic [63:0]              end_a;
        logic [63:0]              bound;
        logic [63:0]              bytes;
        logic [63:0]              remain;
        logic [63:0]              off;
        tl_axi_pkg::axi_a_t       ap;
        tl_axi_pkg::tlp_cpl_hdr_t ch;
        a      = 64'(row.addr);
        remain = 64'({row.len_dw, 2'b00});
        end_a  = a + remain;
        while (a < end_a) begin
            bound = (a / 64'd128 + 64'd1) * 64'd128;
            if (bound > end_a) begin
                bound = end_a;
            end
            bytes   = bound - a;
            ap.addr = a;
            ap.len  = 8'(bytes / 64'd32 - 64'd1);
            exp_ar.push_back(ap);
            ch.fmt_type     = tl_axi_pkg::CPL_D;
            ch.status       = tl_axi_pkg::CPL_SC;
            ch.length_dw    = 10'(bytes / 64'd4);
            ch.completer_id = CFG_BDF;
            ch.byte_count   = 12'(remain);
            ch.requester_id = req_id;
            ch.tag          = row.tag;
            ch.lower_addr   = a[6:0];
            exp_cpl.push_back(ch);
            off = 64'd0;
            while (off < bytes) begin
                exp_rdata.push_back(beat_word(a + off));
                off = off + 64'd32;
            end
            remain = remain - bytes;
            a      = bound;
        end
    endtask

    // One write every other cycle so full is never stale
    task automatic push_p_hdr(input tl_axi_pkg::tlp_req_hdr_t h);
        @(posedge clk);
        while (p_hdr_full_o) @(posedge clk);
        p_hdr_i      <= h;
        p_hdr_wren_i <= 1'b1;
        @(posedge clk);
        p_hdr_wren_i <= 1'b0;
    endtask

    task automatic push_p_data(input logic [255:0] d);
        @(posedge clk);
        while (p_data_full_o) @(posedge clk);
        p_data_i      <= d;
        p_data_wren_i <= 1'b1;
        @(posedge clk);
        p_data_wren_i <= 1'b0;
    endtask

    task automatic push_np_hdr(input tl_axi_pkg::tlp_req_hdr_t h);
        @(posedge clk);
        while (np_hdr_full_o) @(posedge clk);
        np_hdr_i      <= h;
        np_hdr_wren_i <= 1'b1;
        @(posedge clk);
        np_hdr_wren_i <= 1'b0;
    endtask

    // ******************************
    // AXI slave and completion sink
    // ******************************
    always @(posedge clk) begin
        tl_axi_pkg::axi_w_t wexp;
        tl_axi_pkg::axi_r_t beat;
        aw_ready_i <= ($urandom % 4) != 0;
        w_ready_i  <= ($urandom % 4) != 0;
        ar_ready_i <= ($urandom % 4) != 0;
        if (rst_n) begin
            if (aw_valid_o && aw_ready_i) begin
                if (exp_aw.size() == 0) abort_run("AXI write address seen with none expected");
                else check_val("AW addr/len", 256'(aw_o), 256'(exp_aw.pop_front()));
            end
            if (w_valid_o && w_ready_i) begin
                if (exp_w.size() == 0) begin
                    abort_run("AXI write beat seen with none expected");
                end else begin
                    wexp = exp_w.pop_front();
                    check_val("W data", w_o.data, wexp.data);
                    check_val("W last", 256'(w_o.last), 256'(wexp.last));
                end
            end
            if (r_valid_i && r_ready_o) begin
                void'(r_pending.pop_front());
            end
            if (ar_valid_o && ar_ready_i) begin
                if (exp_ar.size() == 0) begin
                    abort_run("AXI read address seen with none expected");
                end else begin
                    check_val("AR addr/len", 256'(ar_o), 256'(exp_ar.pop_front()));
                    for (int i = 0; i <= int'(ar_o.len); i++) begin
                        beat.data = beat_word(ar_o.addr + 64'(i) * 64'd32);
                        beat.last = (i == int'(ar_o.len));
                        r_pending.push_back(beat);
                    end
                end
            end
            r_valid_i <= (r_pending.size() > 0);
            r_i       <= (r_pending.size() > 0) ? r_pending[0] : '0;
            if (cpl_hdr_rden_i) begin
                if (exp_cpl.size() == 0) abort_run("Completion header seen with none expected");
                else check_val("completion header", 256'(cpl_hdr_o), 256'(exp_cpl.pop_front()));
            end
            if (cpl_data_rden_i) begin
                if (exp_rdata.size() == 0) begin
                    abort_run("Completion data seen with none expected");
                end else begin
                    check_val("completion data", cpl_data_o, exp_rdata.pop_front());
                end
            end
            // Random pulls give back-pressure on R
            cpl_hdr_rden_i  <= !cpl_hdr_empty_o && !cpl_hdr_rden_i && (($urandom % 2) != 0);
            cpl_data_rden_i <= !cpl_data_empty_o && !cpl_data_rden_i && (($urandom % 2) != 0);
        end else begin
            r_valid_i       <= 1'b0;
            cpl_hdr_rden_i  <= 1'b0;
            cpl_data_rden_i <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run("Timeout: the bridge did not finish all requests in time");
        end
    end

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        tl_axi_pkg::tlp_req_hdr_t hdr;
        tl_axi_pkg::axi_a_t       aw;
        tl_axi_pkg::axi_w_t       wb;
        void'($urandom(70));
        rst_n           = 1'b0;
        config_bdf_i    = CFG_BDF;
        p_hdr_i         = '0;
        p_hdr_wren_i    = 1'b0;
        p_data_i        = '0;
        p_data_wren_i   = 1'b0;
        np_hdr_i        = '0;
        np_hdr_wren_i   = 1'b0;
        aw_ready_i      = 1'b0;
        w_ready_i       = 1'b0;
        ar_ready_i      = 1'b0;
        r_i             = '0;
        r_valid_i       = 1'b0;
        cpl_hdr_rden_i  = 1'b0;
        cpl_data_rden_i = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_val("aw_valid after reset", 256'(aw_valid_o), 256'(1'b0));
        check_val("w_valid after reset", 256'(w_valid_o), 256'(1'b0));
        check_val("ar_valid after reset", 256'(ar_valid_o), 256'(1'b0));
        check_val("cpl_hdr_empty after reset", 256'(cpl_hdr_empty_o), 256'(1'b1));
        check_val("cpl_data_empty after reset", 256'(cpl_data_empty_o), 256'(1'b1));
        check_val("p_hdr_full after reset", 256'(p_hdr_full_o), 256'(1'b0));
        check_val("p_data_full after reset", 256'(p_data_full_o), 256'(1'b0));
        check_val("np_hdr_full after reset", 256'(np_hdr_full_o), 256'(1'b0));
        check_val("r_ready after reset", 256'(r_ready_o), 256'(1'b1));

        for (int r = 0; r < NUM_ROWS; r++) begin
            hdr.length_dw    = stim[r].len_dw;
            hdr.addr         = 64'(stim[r].addr);
            hdr.tag          = stim[r].tag;
            hdr.requester_id = 16'h0100 + 16'(r);
            if (stim[r].kind == tl_axi_pkg::MEM_WR) begin
                aw.addr = hdr.addr;
                aw.len  = 8'(stim[r].len_dw / 10'd8) - 8'd1;
                exp_aw.push_back(aw);
                push_p_hdr(hdr);
                for (int b = 0; b <= int'(aw.len); b++) begin
                    wb.data = random_beat();
                    wb.last = (b == int'(aw.len));                 // Only the final beat
                    exp_w.push_back(wb);
                    push_p_data(wb.data);
                end
            end else begin
                expect_read(stim[r], hdr.requester_id);
                push_np_hdr(hdr);
            end
        end

        while (!all_done()) @(posedge clk);
        @(posedge clk);
        // Nothing beyond the expected pieces and beats may be left queued
        check_val("cpl_hdr_empty at end", 256'(cpl_hdr_empty_o), 256'(1'b1));
        check_val("cpl_data_empty at end", 256'(cpl_data_empty_o), 256'(1'b1));
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: files.f
hw/tl_axi_pkg.sv
hw/tl_fifo.sv
hw/tl_posted_wr.sv
hw/tl_np_rd_split.sv
hw/tl_axi_master.sv
verif/tb_tl_axi_master.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it once

cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module tb_tl_axi_master -f files.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "Simulation run succeeded" ||
{
    echo "Simulation run did not pass"
    exit 1
}
